// ==== hw/exe_defs.svh ====
`ifndef EXE_DEFS_SVH
`define EXE_DEFS_SVH

// datapath width of the core
`define EXE_XLEN 32

// general register file has 32 entries
`define EXE_RADDR_W 5

// one quotient or multiplier bit per iteration
`define EXE_MD_STEPS 32

// iteration counter width, must hold EXE_MD_STEPS - 1
`define EXE_MD_CNT_W 6

`endif

// ==== hw/isa_pkg.sv ====
package isa_pkg;

    // operation carried out by the execute stage
    typedef enum logic [4:0] {
        ADD,
        ADDU,
        SUB,
        SUBU,
        SLT,
        SLTU,
        AND,
        OR,
        XOR,
        NOR,
        SLL,
        SRL,
        SRA,
        LUI,
        MUL,     // low word of product
        DIV,
        DIVU,
        REM,
        REMU
    } alu_op_e;

    // data memory access, NONE for register-only instructions
    typedef enum logic [3:0] {
        NONE,
        LB,
        LBU,
        LH,
        LHU,
        LW,
        SB,
        SH,
        SW,
        SWL,
        SWR
    } mem_op_e;

    // MIPS cause register ExcCode numbering
    typedef enum logic [4:0] {
        NO_EX = 5'd0,
        ADEL  = 5'd4,   // address error on load
        ADES  = 5'd5,   // address error on store
        OV    = 5'd12   // arithmetic overflow
    } exc_code_e;

endpackage

// ==== hw/stage_pkg.sv ====
`include "exe_defs.svh"

package stage_pkg;

    typedef enum logic [1:0] {
        RS,
        PC,
        SA      // shift amount field of the instruction
    } src1_sel_e;

    typedef enum logic [1:0] {
        RT,
        IMM_ZX,
        IMM_SX,
        CONST8  // return address offset for jal/bal
    } src2_sel_e;

    // decoded instruction handed from decode to execute
    typedef struct packed {
        isa_pkg::alu_op_e        alu_op;
        isa_pkg::mem_op_e        mem_op;
        src1_sel_e               src1_sel;
        src2_sel_e               src2_sel;
        logic                    gr_we;
        logic [`EXE_RADDR_W-1:0] dest;
        logic [15:0]             imm;
        logic [`EXE_XLEN-1:0]    rs_value;
        logic [`EXE_XLEN-1:0]    rt_value;
        logic [`EXE_XLEN-1:0]    pc;
        logic                    ex_in;   // raised by fetch or decode
        isa_pkg::exc_code_e      exc_in;
    } ds_to_es_t;

    // executed instruction handed to the memory stage
    typedef struct packed {
        logic [`EXE_XLEN-1:0]    pc;
        logic [`EXE_XLEN-1:0]    result;  // also the data address
        logic [`EXE_RADDR_W-1:0] dest;
        logic                    gr_we;
        isa_pkg::mem_op_e        mem_op;
        logic [3:0]              mem_wen;
        logic [`EXE_XLEN-1:0]    mem_wdata;
        logic                    ex;
        isa_pkg::exc_code_e      exc;
    } es_to_ms_t;

endpackage

// ==== hw/alu.sv ====
`timescale 1ns/1ns
`include "exe_defs.svh"

module alu (
    input  isa_pkg::alu_op_e     alu_op,
    input  logic [`EXE_XLEN-1:0] src1,
    input  logic [`EXE_XLEN-1:0] src2,
    output logic [`EXE_XLEN-1:0] result,
    output logic                 overflow
);

    localparam int MSB = `EXE_XLEN - 1;

    logic [`EXE_XLEN-1:0] sum;
    logic [`EXE_XLEN-1:0] diff;
    logic                 add_ov;
    logic                 sub_ov;
    logic                 lt_signed;
    logic                 lt_unsigned;
    logic [4:0]           shamt;

    assign sum  = src1 + src2;
    assign diff = src1 - src2;

    // same operand signs but result sign flipped
    assign add_ov = (src1[MSB] == src2[MSB]) && (sum[MSB] != src1[MSB]);
    // operand signs differ and result takes the subtrahend's sign
    assign sub_ov = (src1[MSB] != src2[MSB]) && (diff[MSB] != src1[MSB]);

    assign lt_signed   = $signed(src1) < $signed(src2);
    assign lt_unsigned = src1 < src2;
    assign shamt       = src2[4:0];

    // only the trapping forms report it
    assign overflow = ((alu_op == isa_pkg::ADD) && add_ov) ||
                      ((alu_op == isa_pkg::SUB) && sub_ov);

    always_comb begin
        case (alu_op)
            isa_pkg::ADD,
            isa_pkg::ADDU: result = sum;
            isa_pkg::SUB,
            isa_pkg::SUBU: result = diff;
            isa_pkg::SLT:  result = {{(`EXE_XLEN-1){1'b0}}, lt_signed};
            isa_pkg::SLTU: result = {{(`EXE_XLEN-1){1'b0}}, lt_unsigned};
            isa_pkg::AND:  result = src1 & src2;
            isa_pkg::OR:   result = src1 | src2;
            isa_pkg::XOR:  result = src1 ^ src2;
            isa_pkg::NOR:  result = ~(src1 | src2);
            isa_pkg::SLL:  result = src1 << shamt;
            isa_pkg::SRL:  result = src1 >> shamt;
            isa_pkg::SRA:  result = $signed(src1) >>> shamt;
            isa_pkg::LUI:  result = {src2[15:0], 16'h0000};
            default:       result = '0;   // muldiv ops come from the iterative unit
        endcase
    end

endmodule

// ==== hw/muldiv_unit.sv ====
`timescale 1ns/1ns
`include "exe_defs.svh"

module muldiv_unit (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    input  logic                 ack,
    input  logic                 abort,
    input  isa_pkg::alu_op_e     op,
    input  logic [`EXE_XLEN-1:0] a,
    input  logic [`EXE_XLEN-1:0] b,
    output logic                 done,
    output logic [`EXE_XLEN-1:0] result
);

    localparam int MSB = `EXE_XLEN - 1;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } state_e;

    state_e                   state;
    logic [`EXE_MD_CNT_W-1:0] cnt;
    isa_pkg::alu_op_e         op_r;
    logic [`EXE_XLEN-1:0]     acc;    // product or partial remainder
    logic [`EXE_XLEN-1:0]     q;      // multiplier or dividend, becomes quotient
    logic [`EXE_XLEN-1:0]     opb;    // multiplicand or divisor magnitude
    logic                     a_neg;
    logic                     b_neg;
    logic                     b_zero;
    logic                     is_mul;
    logic                     is_signed;
    logic [`EXE_XLEN-1:0]     a_mag;
    logic [`EXE_XLEN-1:0]     b_mag;
    logic [`EXE_XLEN:0]       partial;
    logic                     fits;

    assign is_mul    = (op == isa_pkg::MUL);
    assign is_signed = (op == isa_pkg::DIV) || (op == isa_pkg::REM);
    assign a_mag     = (is_signed && a[MSB]) ? -a : a;
    assign b_mag     = (is_signed && b[MSB]) ? -b : b;

    // restoring step: bring down next dividend bit, try to subtract
    assign partial = {acc, q[MSB]};
    assign fits    = partial >= {1'b0, opb};

    always_ff @(posedge clk) begin
        if (reset || abort) begin
            state <= IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                IDLE: if (start) begin
                    state <= RUN;
                    cnt   <= '0;
                end
                RUN: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == `EXE_MD_CNT_W'(`EXE_MD_STEPS - 1))
                        state <= DONE;
                end
                DONE: if (ack) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            op_r   <= op;
            acc    <= '0;
            q      <= is_mul ? a : a_mag;
            opb    <= is_mul ? b : b_mag;   // low product word ignores sign
            a_neg  <= is_signed && a[MSB];
            b_neg  <= is_signed && b[MSB];
            b_zero <= (b == '0);
        end else if (state == RUN) begin
            if (op_r == isa_pkg::MUL)
                acc <= {acc[MSB-1:0], 1'b0} + (q[MSB] ? opb : '0);   // msb first
            else if (fits)
                acc <= partial[MSB:0] - opb;
            else
                acc <= partial[MSB:0];
            q <= {q[MSB-1:0], (op_r != isa_pkg::MUL) && fits};
        end
    end

    assign done = (state == DONE);

    // sign fix-up on the held magnitudes
    always_comb begin
        case (op_r)
            isa_pkg::MUL:  result = acc;
            isa_pkg::DIV:  result = b_zero ? '1 : ((a_neg ^ b_neg) ? -q : q);
            isa_pkg::REM:  result = a_neg ? -acc : acc;   // gives dividend back on zero
            isa_pkg::REMU: result = acc;
            default:       result = q;
        endcase
    end

endmodule

// ==== hw/store_align.sv ====
`timescale 1ns/1ns
`include "exe_defs.svh"

module store_align (
    input  isa_pkg::mem_op_e     mem_op,
    input  logic [`EXE_XLEN-1:0] addr,
    input  logic [`EXE_XLEN-1:0] rt_value,
    output logic [3:0]           wen,
    output logic [`EXE_XLEN-1:0] wdata,
    output logic                 ades,
    output logic                 adel
);

    logic [1:0] ofs;
    logic [1:0] ofs_inv;

    assign ofs     = addr[1:0];
    assign ofs_inv = 2'd3 - ofs;   // bytes above the addressed one

    always_comb begin
        wen   = 4'b0000;
        wdata = rt_value;
        ades  = 1'b0;
        adel  = 1'b0;
        case (mem_op)
            isa_pkg::SB: begin
                wen   = 4'b0001 << ofs;
                wdata = {4{rt_value[7:0]}};
            end
            isa_pkg::SH: begin
                wen   = ofs[1] ? 4'b1100 : 4'b0011;
                wdata = {2{rt_value[15:0]}};
                ades  = ofs[0];
            end
            isa_pkg::SW: begin
                wen  = 4'b1111;
                ades = |ofs;
            end
            // swl writes the upper part of rt into the low bytes up to addr
            isa_pkg::SWL: begin
                wen   = 4'b1111 >> ofs_inv;
                wdata = rt_value >> {ofs_inv, 3'b000};
            end
            // swr writes the lower part of rt from addr upwards
            isa_pkg::SWR: begin
                wen   = 4'b1111 << ofs;
                wdata = rt_value << {ofs, 3'b000};
            end
            isa_pkg::LH,
            isa_pkg::LHU: adel = ofs[0];
            isa_pkg::LW:  adel = |ofs;
            default: ;   // byte loads and plain alu ops
        endcase
    end

endmodule

// ==== hw/exe_stage.sv ====
`timescale 1ns/1ns
`include "exe_defs.svh"

module exe_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 ds_to_es_valid,
    input  stage_pkg::ds_to_es_t ds_to_es_bus,
    output logic                 es_allowin,
    input  logic                 ms_allowin,
    output logic                 es_to_ms_valid,
    output stage_pkg::es_to_ms_t es_to_ms_bus,
    input  logic                 flush
);

    logic                 es_valid;
    logic                 es_ready_go;
    logic                 es_accept;
    logic                 es_leave;
    stage_pkg::ds_to_es_t es_r;

    logic [`EXE_XLEN-1:0] src1;
    logic [`EXE_XLEN-1:0] src2;
    logic [`EXE_XLEN-1:0] alu_result;
    logic                 alu_overflow;
    logic [`EXE_XLEN-1:0] md_result;
    logic [`EXE_XLEN-1:0] es_result;

    logic                 is_md;
    logic                 md_issued;   // start already sent for this instruction
    logic                 md_start;
    logic                 md_done;
    logic                 md_ack;

    logic [3:0]           st_wen;
    logic [`EXE_XLEN-1:0] st_wdata;
    logic                 ades;
    logic                 adel;
    logic                 es_ex;
    isa_pkg::exc_code_e   es_exc;

    assign is_md = es_r.alu_op inside {isa_pkg::MUL, isa_pkg::DIV, isa_pkg::DIVU,
                                       isa_pkg::REM, isa_pkg::REMU};

    assign es_ready_go    = is_md ? md_done : 1'b1;
    assign es_allowin     = !flush && (!es_valid || (es_ready_go && ms_allowin));
    assign es_to_ms_valid = es_valid && es_ready_go;
    assign es_accept      = ds_to_es_valid && es_allowin;
    assign es_leave       = es_to_ms_valid && ms_allowin;

    always_ff @(posedge clk) begin
        if (reset || flush)
            es_valid <= 1'b0;
        else if (es_allowin)
            es_valid <= ds_to_es_valid;
    end

    always_ff @(posedge clk) begin
        if (es_accept)
            es_r <= ds_to_es_bus;
    end

    // operand select
    always_comb begin
        case (es_r.src1_sel)
            stage_pkg::PC: src1 = es_r.pc;
            stage_pkg::SA: src1 = {{(`EXE_XLEN-5){1'b0}}, es_r.imm[10:6]};
            default:       src1 = es_r.rs_value;
        endcase
        case (es_r.src2_sel)
            stage_pkg::IMM_ZX: src2 = {{(`EXE_XLEN-16){1'b0}}, es_r.imm};
            stage_pkg::IMM_SX: src2 = {{(`EXE_XLEN-16){es_r.imm[15]}}, es_r.imm};
            stage_pkg::CONST8: src2 = `EXE_XLEN'(8);
            default:           src2 = es_r.rt_value;
        endcase
    end

    alu u_alu (
        .alu_op   (es_r.alu_op),
        .src1     (src1),
        .src2     (src2),
        .result   (alu_result),
        .overflow (alu_overflow)
    );

    // one start pulse in the cycle after a muldiv op is registered
    always_ff @(posedge clk) begin
        if (reset || flush || es_accept)
            md_issued <= 1'b0;
        else if (md_start)
            md_issued <= 1'b1;
    end

    assign md_start = es_valid && is_md && !md_issued;
    assign md_ack   = es_valid && is_md && (es_leave || flush);

    muldiv_unit u_muldiv (
        .clk    (clk),
        .reset  (reset),
        .start  (md_start),
        .ack    (md_ack),
        .abort  (flush),
        .op     (es_r.alu_op),
        .a      (src1),
        .b      (src2),
        .done   (md_done),
        .result (md_result)
    );

    assign es_result = is_md ? md_result : alu_result;

    store_align u_store_align (
        .mem_op   (es_r.mem_op),
        .addr     (es_result),
        .rt_value (es_r.rt_value),
        .wen      (st_wen),
        .wdata    (st_wdata),
        .ades     (ades),
        .adel     (adel)
    );

    // earlier stage wins, then overflow, then store and load address errors
    assign es_ex  = es_r.ex_in || alu_overflow || ades || adel;
    assign es_exc = es_r.ex_in   ? es_r.exc_in :
                    alu_overflow ? isa_pkg::OV :
                    ades         ? isa_pkg::ADES :
                    adel         ? isa_pkg::ADEL : isa_pkg::NO_EX;

    always_comb begin
        es_to_ms_bus.pc        = es_r.pc;
        es_to_ms_bus.result    = es_result;
        es_to_ms_bus.dest      = es_r.dest;
        es_to_ms_bus.gr_we     = es_r.gr_we && !es_ex;   // no write-back when excepting
        es_to_ms_bus.mem_op    = es_r.mem_op;
        es_to_ms_bus.mem_wen   = es_ex ? 4'b0000 : st_wen;
        es_to_ms_bus.mem_wdata = st_wdata;
        es_to_ms_bus.ex        = es_ex;
        es_to_ms_bus.exc       = es_exc;
    end

endmodule

// ==== dv/exe_stage_tb.sv ====
`timescale 1ns/1ns
`include "exe_defs.svh"

module exe_stage_tb;

    localparam int NCOL    = 18;
    localparam int VEC_MAX = 64;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] dest;
        logic        gr_we;
        logic [3:0]  mem_op;
        logic [31:0] result;
        logic [3:0]  wen;
        logic [31:0] wdata;
        logic        ex;
        logic [4:0]  exc;
        logic        is_store;
    } exp_t;

    logic                 clk;
    logic                 reset;
    logic                 ds_to_es_valid;
    stage_pkg::ds_to_es_t ds_to_es_bus;
    logic                 es_allowin;
    logic                 ms_allowin;
    logic                 es_to_ms_valid;
    stage_pkg::es_to_ms_t es_to_ms_bus;
    logic                 flush;

    logic [31:0] vec_mem [0:VEC_MAX*NCOL-1];
    exp_t        exp_q[$];
    int          n_vec;
    int          accepted;
    int          exp_total;
    int          out_count;
    logic        loaded;

    exe_stage UUT (
        .clk            (clk),
        .reset          (reset),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es_bus   (ds_to_es_bus),
        .es_allowin     (es_allowin),
        .ms_allowin     (ms_allowin),
        .es_to_ms_valid (es_to_ms_valid),
        .es_to_ms_bus   (es_to_ms_bus),
        .flush          (flush)
    );

    task automatic check_value(input string what, input logic [127:0] actual,
                               input logic [127:0] expected);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("Test FAILED");
            $fatal(1, "mismatch");
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // memory side stalls about 30 percent of cycles
    initial begin
        void'($urandom(32'h94cd));
        ms_allowin = 1'b0;
        forever begin
            @(posedge clk);
            ms_allowin <= ($urandom % 100) >= 30;
        end
    end

    initial begin
        wait (loaded);
        repeat (8 + n_vec * (`EXE_MD_STEPS + 4) * 4) @(posedge clk);
        $display("Run hung: outputs stopped arriving before all vectors were done");
        $display("Test FAILED");
        $fatal(1, "watchdog");
    end

    // output order, contents and stability under stall
    initial begin
        exp_t                 e;
        logic                 held;
        stage_pkg::es_to_ms_t held_bus;
        held = 1'b0;
        forever begin
            @(posedge clk);
            if (!reset) begin
                if (accepted == 0)
                    check_value("es_to_ms_valid before first accept",
                                128'(es_to_ms_valid), '0);
                if (held) begin
                    check_value("stalled es_to_ms_valid", 128'(es_to_ms_valid), 128'(1));
                    check_value("stalled bus", 128'(es_to_ms_bus), 128'(held_bus));
                end
                if (es_to_ms_valid && ms_allowin) begin
                    if (exp_q.size() == 0) begin
                        $display("Unexpected output with nothing pending at %0t ns", $time);
                        $display("Test FAILED");
                        $fatal(1, "extra output");
                    end else begin
                        e = exp_q.pop_front();
                        check_value("pc", 128'(es_to_ms_bus.pc), 128'(e.pc));
                        check_value("result", 128'(es_to_ms_bus.result), 128'(e.result));
                        check_value("dest", 128'(es_to_ms_bus.dest), 128'(e.dest));
                        check_value("gr_we", 128'(es_to_ms_bus.gr_we), 128'(e.gr_we));
                        check_value("mem_op", 128'(es_to_ms_bus.mem_op), 128'(e.mem_op));
                        check_value("mem_wen", 128'(es_to_ms_bus.mem_wen), 128'(e.wen));
                        if (e.is_store)
                            check_value("mem_wdata", 128'(es_to_ms_bus.mem_wdata),
                                        128'(e.wdata));
                        check_value("ex", 128'(es_to_ms_bus.ex), 128'(e.ex));
                        check_value("exc", 128'(es_to_ms_bus.exc), 128'(e.exc));
                        out_count++;
                    end
                end
                held     = es_to_ms_valid && !ms_allowin;
                held_bus = es_to_ms_bus;
            end
        end
    end

    initial begin
        int   b;
        exp_t e;
        reset          = 1'b1;
        ds_to_es_valid = 1'b0;
        ds_to_es_bus   = '0;
        flush          = 1'b0;
        accepted       = 0;
        exp_total      = 0;
        out_count      = 0;
        loaded         = 1'b0;
        for (int i = 0; i < VEC_MAX * NCOL; i++)
            vec_mem[i] = 32'hdead0000 | i;   // op column above 31 marks the end
        $readmemh("dv/exe_vectors.txt", vec_mem);
        n_vec = 0;
        while (n_vec < VEC_MAX && vec_mem[n_vec * NCOL] < 32)
            n_vec++;
        loaded = 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        for (int i = 0; i < n_vec; i++) begin
            b = i * NCOL;
            ds_to_es_valid        <= 1'b1;
            ds_to_es_bus.alu_op   <= isa_pkg::alu_op_e'(vec_mem[b][4:0]);
            ds_to_es_bus.mem_op   <= isa_pkg::mem_op_e'(vec_mem[b+1][3:0]);
            ds_to_es_bus.src1_sel <= stage_pkg::src1_sel_e'(vec_mem[b+2][1:0]);
            ds_to_es_bus.src2_sel <= stage_pkg::src2_sel_e'(vec_mem[b+3][1:0]);
            ds_to_es_bus.gr_we    <= vec_mem[b+4][0];
            ds_to_es_bus.dest     <= vec_mem[b+5][`EXE_RADDR_W-1:0];
            ds_to_es_bus.imm      <= vec_mem[b+6][15:0];
            ds_to_es_bus.rs_value <= vec_mem[b+7];
            ds_to_es_bus.rt_value <= vec_mem[b+8];
            ds_to_es_bus.pc       <= vec_mem[b+9];
            ds_to_es_bus.ex_in    <= vec_mem[b+10][0];
            ds_to_es_bus.exc_in   <= isa_pkg::exc_code_e'(vec_mem[b+11][4:0]);
            do @(posedge clk); while (!es_allowin);
            accepted++;
            if (vec_mem[b+12][0]) begin
                // drop it a few cycles into the iteration
                ds_to_es_valid <= 1'b0;
                repeat (4) @(posedge clk);
                flush <= 1'b1;
                @(posedge clk);
                flush <= 1'b0;
            end else begin
                e.pc       = vec_mem[b+9];
                e.dest     = vec_mem[b+5] & 32'h1f;
                e.ex       = vec_mem[b+16][0];
                e.gr_we    = vec_mem[b+4][0] && !e.ex;
                e.mem_op   = vec_mem[b+1][3:0];
                e.result   = vec_mem[b+13];
                e.wen      = vec_mem[b+14][3:0];
                e.wdata    = vec_mem[b+15];
                e.exc      = vec_mem[b+17][4:0];
                e.is_store = vec_mem[b+1] >= 6 && vec_mem[b+1] <= 10;
                exp_q.push_back(e);
                exp_total++;
            end
        end
        ds_to_es_valid <= 1'b0;

        while (exp_q.size() != 0)
            @(posedge clk);
        repeat (4) @(posedge clk);
        if (out_count != exp_total) begin
            $display("Output count %0d differs from expected %0d", out_count, exp_total);
            $display("Test FAILED");
            $fatal(1, "count");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

// ==== all.f ====
+incdir+hw
hw/isa_pkg.sv
hw/stage_pkg.sv
hw/alu.sv
hw/muldiv_unit.sv
hw/store_align.sv
hw/exe_stage.sv
dv/exe_stage_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= exe_stage_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= all.f
VFLAGS    ?= --binary --timing -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := hw/exe_defs.svh
VECS := dv/exe_vectors.txt
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# vector file path is relative to the project root
run: $(BIN) $(VECS)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/exe_vectors.txt ====
// alu mem s1 s2 we dest imm rs rt pc ex_in exc_in flush | exp: result wen wdata ex exc
// all hex; ops and selects use the enum encodings, expected columns ignored on flush lines
0 0 0 0 1 2 0 5 7 100 0 0 0  c 0 0 0 0
0 0 0 0 1 3 0 7fffffff 1 104 0 0 0  80000000 0 0 1 c
1 0 0 0 1 3 0 7fffffff 1 108 0 0 0  80000000 0 0 0 0
2 0 0 0 1 4 0 80000000 1 10c 0 0 0  7fffffff 0 0 1 c
3 0 0 0 1 4 0 3 5 110 0 0 0  fffffffe 0 0 0 0
4 0 0 0 1 5 0 ffffffff 1 114 0 0 0  1 0 0 0 0
5 0 0 0 1 5 0 ffffffff 1 118 0 0 0  0 0 0 0 0
7 0 0 1 1 6 8001 10 0 11c 0 0 0  8011 0 0 0 0
1 0 0 2 1 6 fff0 100 0 120 0 0 0  f0 0 0 0 0
a 0 2 0 1 7 100 0 3 124 0 0 0  20 0 0 0 0
c 0 0 0 1 7 0 80000000 4 128 0 0 0  f8000000 0 0 0 0
1 0 1 3 1 1f 0 0 0 12c 0 0 0  134 0 0 0 0
d 0 0 1 1 8 1234 0 0 130 0 0 0  12340000 0 0 0 0
9 0 0 0 1 8 0 0f0f0f0f 00ff00ff 134 0 0 0  f000f000 0 0 0 0
e 0 0 0 1 9 0 fffffffd 7 138 0 0 0  ffffffeb 0 0 0 0
e 0 0 0 1 9 0 12345678 10 13c 0 0 0  23456780 0 0 0 0
f 0 0 0 1 a 0 ffffffec 3 140 0 0 0  fffffffa 0 0 0 0
11 0 0 0 1 a 0 ffffffec 3 144 0 0 0  fffffffe 0 0 0 0
10 0 0 0 1 b 0 64 0 148 0 0 0  ffffffff 0 0 0 0
12 0 0 0 1 b 0 64 0 14c 0 0 0  64 0 0 0 0
1 6 0 2 0 0 3 1000 aabbccdd 150 0 0 0  1003 8 dddddddd 0 0
1 7 0 2 0 0 2 1000 aabbccdd 154 0 0 0  1002 c ccddccdd 0 0
1 7 0 2 0 0 1 1000 aabbccdd 158 0 0 0  1001 0 ccddccdd 1 5
1 8 0 2 0 0 0 1000 aabbccdd 15c 0 0 0  1000 f aabbccdd 0 0
1 9 0 2 0 0 1 1000 aabbccdd 160 0 0 0  1001 3 0000aabb 0 0
1 a 0 2 0 0 2 1000 aabbccdd 164 0 0 0  1002 c ccdd0000 0 0
1 5 0 2 1 c 2 1000 0 168 0 0 0  1002 0 0 1 4
1 4 0 2 1 c 3 1000 0 16c 0 0 0  1003 0 0 1 4
0 8 0 2 1 d 3 7fffffff 11 170 1 a 0  80000002 0 11 1 a
f 0 0 0 1 e 0 100 7 174 0 0 1  0 0 0 0 0
0 0 0 0 1 e 0 1 2 178 0 0 0  3 0 0 0 0
12 0 0 0 1 f 0 64 7 17c 0 0 0  2 0 0 0 0
